/* verification/ucode_tests.txt */
// Records of four hex words: kind, then 1 load = addr word 0, 2 write-back = flags(A=2,M=1) addr data,
// 3 halt = pc 0 0, 0 = end of tests. Each section is loads, write-backs in order, halt.
// Section 1: ALU functions, BYTE rotate, M readback, destination address wrap for M
1 00 0E031000 0
1 01 04272000 0
1 02 200633FF 0
1 03 06053000 0
1 04 0C6E4000 0
1 05 088A5000 0
1 06 0A6B6000 0
1 07 021A7000 0
1 08 00E10000 0
1 09 10E28000 0
1 0A 0E81C000 0
1 0B 02129000 0
1 0C 80000000 0
2 3 1 00000001
2 3 2 00000002
2 2 3 80000000
2 1 3 FFFFFFFF
2 2 4 7FFFFFFF
2 2 5 00000002
2 3 6 80000002
2 2 7 80000002
2 1 0 80000002
2 2 8 00000000
2 1 C 80000000
2 2 9 80000000
3 0C 0 0
// Section 2: pads zero after reset, BYTE masks, every jump condition, halt with write-back
1 00 00A21000 0
1 01 0E031000 0
1 02 04272000 0
1 03 044B3000 0
1 04 06074000 0
1 05 200E53DF 0
1 06 0C8D5000 0
1 07 20166065 0
1 08 4224000B 0
1 0B 448C000E 0
1 0E 46480009 0
1 0F 44640009 0
1 10 424C0009 0
1 11 046E7000 0
1 12 46E80015 0
1 15 40000018 0
1 18 8EE17000 0
2 2 1 00000000
2 3 1 00000001
2 3 2 00000002
2 3 3 00000004
2 3 4 FFFFFFFF
2 2 5 00000001
2 1 5 FFFFFFFB
2 2 6 0000001F
2 2 7 00000008
2 1 7 00000009
3 18 0 0
0 0 0 0

/* compile.f */
hdl/ucode_pkg.sv
hdl/uinst_store.sv
hdl/useq.sv
hdl/operand_read.sv
hdl/alu_shift.sv
hdl/ucode_core.sv
verification/ucode_sva.sv
verification/ucode_checker.sv
verification/ucode_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the microcode core testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module ucode_tb -o ucode_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/ucode_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
   exit 0
fi
exit 1

/* verification/ucode_tb.sv */
// Testbench top with clock, reset, microcode loading, run control and closing report
`timescale 1ns/1ps

module ucode_tb;

   import ucode_pkg::*;

   localparam int PC_W        = 8;
   localparam int TEST_DEPTH  = 512;            // Words in the test file
   localparam int RUN_TIMEOUT = 4000;           // Cycles allowed per program
   localparam int REC_LOAD    = 1;              // Record kinds in the first word
   localparam int REC_WB      = 2;
   localparam int REC_HALT    = 3;

   logic                  clk;
   logic                  reset;
   logic                  run;
   logic                  prog_we;
   logic [PC_W-1:0]       prog_addr;
   uinst_t                prog_data;
   logic [PC_W-1:0]       pc;
   logic                  wb_strobe;
   logic                  wb_a;
   logic                  wb_m;
   logic [A_ADDR_W-1:0]   wb_addr;
   data_t                 wb_data;
   logic                  halted;

   logic [31:0]           tests [TEST_DEPTH];   // Four words per record
   logic [31:0]           rnd;                  // Xorshift state
   int                    rec;                  // Word index of current record
   int                    sections;
   int                    timeouts;
   int                    other_errors;
   int                    value_errors;
   int                    seq_errors;
   int                    halts_seen;

   ucode_core #(.PC_W(PC_W)) UUT (
      .clk(clk), .reset(reset), .run(run), .prog_we(prog_we),
      .prog_addr(prog_addr), .prog_data(prog_data), .pc(pc),
      .wb_strobe(wb_strobe), .wb_a(wb_a), .wb_m(wb_m),
      .wb_addr(wb_addr), .wb_data(wb_data), .halted(halted)
   );

   ucode_checker #(.PC_W(PC_W)) u_checker (
      .clk(clk), .reset(reset), .pc(pc), .wb_strobe(wb_strobe),
      .wb_a(wb_a), .wb_m(wb_m), .wb_addr(wb_addr), .wb_data(wb_data),
      .halted(halted), .value_errors(value_errors), .seq_errors(seq_errors),
      .halts_seen(halts_seen)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;                    // 4 ns period
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   ////////////////////
   // Sequence tasks
   task automatic apply_reset();
      reset <= 1'b1;
      run   <= 1'b0;
      repeat (3) @(posedge clk);                // Three reset cycles
      reset <= 1'b0;
   endtask

   // Store words of one section while the machine is stopped
   task automatic load_section();
      while (rec < TEST_DEPTH - 4 && tests[rec] == REC_LOAD) begin
         @(posedge clk);
         prog_we   <= 1'b1;
         prog_addr <= tests[rec+1][PC_W-1:0];
         prog_data <= tests[rec+2];
         rec += 4;
      end
      @(posedge clk);
      prog_we <= 1'b0;
      while (rec < TEST_DEPTH - 4 && tests[rec] == REC_WB) rec += 4;   // Checker's records
      if (tests[rec] == REC_HALT) rec += 4;
   endtask

   // Run high and low in random spans until halted
   task automatic run_until_halt();
      int   cycles;
      int   span;
      logic run_now;
      cycles  = 0;
      span    = 0;
      run_now = 1'b0;
      while (!halted && cycles < RUN_TIMEOUT) begin
         @(posedge clk);
         cycles++;
         if (span == 0) begin
            rnd     = xorshift32(rnd);
            run_now = ~run_now;
            span    = run_now ? 3 + int'(rnd[3:0]) : 1 + int'(rnd[2:0]);   // Short stalls
         end
         span--;
         run <= run_now;
      end
      if (!halted) begin
         timeouts++;
         $display("Timeout: machine did not halt within %0d cycles", RUN_TIMEOUT);
      end
      run <= 1'b0;
   endtask

   ////////////////////
   // Main sequence
   initial begin
      reset        = 1'b1;
      run          = 1'b0;
      prog_we      = 1'b0;
      prog_addr    = '0;
      prog_data    = '0;
      rnd          = 32'h9ff9;
      rec          = 0;
      sections     = 0;
      timeouts     = 0;
      other_errors = 0;
      $readmemh("verification/ucode_tests.txt", tests);
      while (tests[rec] == REC_LOAD && timeouts == 0) begin
         apply_reset();
         load_section();
         run_until_halt();
         sections++;
         repeat (2) @(posedge clk);             // Let the checker see the halt
      end
      if (sections == 0) begin
         other_errors++;
         $display("No test sections were found in the test file");
      end else if (halts_seen != sections) begin
         other_errors++;
         $display("Checker saw %0d halts for %0d sections", halts_seen, sections);
      end
      $display("Errors: value %0d, sequence %0d, timeout %0d, other %0d",
               value_errors, seq_errors, timeouts, other_errors);
      if (value_errors + seq_errors + timeouts + other_errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

/* verification/ucode_checker.sv */
// Checker comparing DUT write-backs and halt pc with the expectations in the test file
`timescale 1ns/1ps

module ucode_checker #(
   parameter int PC_W = 8
) (
   input  logic                            clk,
   input  logic                            reset,
   input  logic [PC_W-1:0]                 pc,
   input  logic                            wb_strobe,
   input  logic                            wb_a,
   input  logic                            wb_m,
   input  logic [ucode_pkg::A_ADDR_W-1:0]  wb_addr,
   input  ucode_pkg::data_t                wb_data,
   input  logic                            halted,
   output int                              value_errors,
   output int                              seq_errors,
   output int                              halts_seen
);

   import ucode_pkg::*;

   localparam int TEST_DEPTH = 512;
   localparam int REC_LOAD   = 1;
   localparam int REC_WB     = 2;               // Flags, address, data
   localparam int REC_HALT   = 3;               // Halt pc

   logic [31:0] tests [TEST_DEPTH];
   int          idx      = 0;                   // Next expectation record
   int          n_value  = 0;
   int          n_seq    = 0;
   int          n_halt   = 0;
   logic        started  = 1'b0;
   logic        reset_q  = 1'b0;
   logic        halted_q = 1'b0;                // Halt edge detect

   assign value_errors = n_value;
   assign seq_errors   = n_seq;
   assign halts_seen   = n_halt;

   initial $readmemh("verification/ucode_tests.txt", tests);

   function automatic int skip_loads(input int from);
      int i;
      i = from;
      while (i < TEST_DEPTH - 4 && tests[i] == REC_LOAD) i += 4;
      return i;
   endfunction

   task automatic compare_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
      if (actual !== expected) begin
         n_value++;
         $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
      end
   endtask

   always @(posedge clk) begin
      if (!started) begin
         idx     = skip_loads(0);               // First expectation
         started = 1'b1;
      end
      // Outputs quiet on the first cycle out of reset
      if (reset_q && !reset) begin
         compare_value("wb_strobe", 32'd0, {31'b0, wb_strobe});
         compare_value("halted", 32'd0, {31'b0, halted});
      end
      if (!reset && wb_strobe) begin
         if (tests[idx] != REC_WB) begin
            n_seq++;
            $display("Unexpected write-back to address %h at time %0t", wb_addr, $time);
         end else begin
            compare_value("wb_a", {31'b0, tests[idx+1][1]}, {31'b0, wb_a});
            compare_value("wb_m", {31'b0, tests[idx+1][0]}, {31'b0, wb_m});
            compare_value("wb_addr", tests[idx+2], {28'b0, wb_addr});
            compare_value("wb_data", tests[idx+3], wb_data);
            idx += 4;
         end
      end
      if (!reset && halted && !halted_q) begin
         while (idx < TEST_DEPTH - 4 && tests[idx] == REC_WB) begin
            n_seq++;
            $display("Missing write-back to address %h before the halt at time %0t",
                     tests[idx+2], $time);
            idx += 4;
         end
         if (tests[idx] == REC_HALT) begin
            compare_value("pc", tests[idx+1], {{(32-PC_W){1'b0}}, pc});
            n_halt++;
            idx = skip_loads(idx + 4);          // Next section's expectations
         end else begin
            n_seq++;
            $display("Halt at time %0t where no halt was expected", $time);
         end
      end
      reset_q  <= reset;
      halted_q <= halted;
   end

endmodule

/* verification/ucode_sva.sv */
// Bound assertions on sequencer state, write-back strobe and halt flag
`timescale 1ns/1ps

module ucode_sva (
   input  logic                      clk,
   input  logic                      reset,
   input  ucode_pkg::ucode_state_e   state,
   input  logic                      wb_strobe,
   input  logic                      halted
);

   import ucode_pkg::*;

   // RESET state lasts one cycle past reset, one-hot after that
   a_state_onehot: assert property (@(posedge clk) disable iff (reset)
      !$past(reset) |-> $onehot(state))
      else $error("Sequencer state %b is not one-hot", state);

   a_wb_in_write: assert property (@(posedge clk) disable iff (reset)
      wb_strobe |-> state == ST_WRITE)
      else $error("Write-back strobe outside the write state");

   a_halt_sticky: assert property (@(posedge clk) disable iff (reset)
      halted |=> halted)                        // Only reset clears halt
      else $error("Halt flag dropped without reset");

endmodule

bind ucode_core ucode_sva u_sva (
   .clk(clk), .reset(reset), .state(u_useq.state),
   .wb_strobe(wb_strobe), .halted(halted)
);

/* hdl/ucode_core.sv */
// Top level of the microcoded data path, connecting sequencer, store, operands and ALU
`timescale 1ns/1ps

module ucode_core #(
   parameter int PC_W = 8                       // Up to 12
) (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic                                  run,
   input  logic                                  prog_we,
   input  logic [PC_W-1:0]                       prog_addr,
   input  ucode_pkg::uinst_t                     prog_data,
   output logic [PC_W-1:0]                       pc,
   output logic                                  wb_strobe,
   output logic                                  wb_a,
   output logic                                  wb_m,
   output logic [ucode_pkg::A_ADDR_W-1:0]        wb_addr,
   output ucode_pkg::data_t                      wb_data,
   output logic                                  halted
);

   import ucode_pkg::*;

   logic              state_read;
   logic              state_alu;
   logic              state_write;
   logic              state_fetch;
   logic [PC_W-1:0]   fetch_addr;
   uinst_t            ir;
   data_t             a_op;
   data_t             m_op;
   data_t             l_data;
   logic              jump_taken;

   ////////////////////
   // Sequencing
   useq #(.PC_W(PC_W)) u_useq (
      .clk(clk), .reset(reset), .run(run), .ir(ir), .jump_taken(jump_taken),
      .state_read(state_read), .state_alu(state_alu), .state_write(state_write),
      .state_fetch(state_fetch), .pc(pc), .fetch_addr(fetch_addr), .halted(halted)
   );

   uinst_store #(.PC_W(PC_W)) u_store (
      .clk(clk), .reset(reset), .state_fetch(state_fetch), .fetch_addr(fetch_addr),
      .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data), .ir(ir)
   );

   ////////////////////
   // Data path
   operand_read u_operands (
      .clk(clk), .reset(reset), .state_read(state_read), .state_write(state_write),
      .ir(ir), .l_data(l_data), .a_op(a_op), .m_op(m_op),
      .wb_strobe(wb_strobe), .wb_a(wb_a), .wb_m(wb_m),
      .wb_addr(wb_addr), .wb_data(wb_data)
   );

   alu_shift u_alu (
      .clk(clk), .reset(reset), .state_alu(state_alu), .ir(ir),
      .a_op(a_op), .m_op(m_op), .l_data(l_data), .jump_taken(jump_taken)
   );

endmodule

/* hdl/alu_shift.sv */
// ALU, byte rotator and mask generator, result select, L register and jump condition
`timescale 1ns/1ps

module alu_shift (
   input  logic                clk,
   input  logic                reset,
   input  logic                state_alu,       // Register L and jump
   input  ucode_pkg::uinst_t   ir,
   input  ucode_pkg::data_t    a_op,
   input  ucode_pkg::data_t    m_op,
   output ucode_pkg::data_t    l_data,          // L register
   output logic                jump_taken
);

   import ucode_pkg::*;

   uinst_kind_e                kind;
   alu_func_e                  func;
   jump_cond_e                 cond;
   logic [ROT_HI-ROT_LO:0]     rot;
   logic [MASK_W_HI-MASK_W_LO:0] mask_w;
   data_t                      alu_out;
   logic [2*DATA_W-1:0]        dbl;             // M twice, for the rotate
   data_t                      rotated;
   data_t                      mask;
   data_t                      byte_out;
   data_t                      result;
   logic                       a_eq_m;
   logic                       a_lt_m;
   logic                       cond_true;

   assign kind   = uinst_kind_e'(ir[KIND_HI:KIND_LO]);
   assign func   = alu_func_e'(ir[FUNC_HI:FUNC_LO]);
   assign cond   = jump_cond_e'(ir[FUNC_LO+1:FUNC_LO]);   // Low 2 bits of FUNC
   assign rot    = ir[ROT_HI:ROT_LO];
   assign mask_w = ir[MASK_W_HI:MASK_W_LO];

   ////////////////////
   // ALU
   always_comb begin
      case (func)
         FN_PASS_A: alu_out = a_op;
         FN_PASS_M: alu_out = m_op;
         FN_ADD:    alu_out = a_op + m_op;
         FN_SUB:    alu_out = a_op - m_op;
         FN_AND:    alu_out = a_op & m_op;
         FN_OR:     alu_out = a_op | m_op;
         FN_XOR:    alu_out = a_op ^ m_op;
         FN_INC_A:  alu_out = a_op + 1'b1;
         default:   alu_out = '0;               // Unused codes
      endcase
   end

   ////////////////////
   // Byte field extractor
   assign dbl      = {m_op, m_op} << rot;
   assign rotated  = dbl[2*DATA_W-1:DATA_W];    // M rotated left by ROT
   assign mask     = {DATA_W{1'b1}} >> (DATA_W - 1 - mask_w);   // MASK_W+1 ones
   assign byte_out = rotated & mask;

   assign result = (kind == K_BYTE) ? byte_out : alu_out;

   // Jump condition on the latched operands
   assign a_eq_m = (a_op == m_op);
   assign a_lt_m = ($signed(a_op) < $signed(m_op));

   always_comb begin
      unique case (cond)
         JC_ALWAYS:    cond_true = 1'b1;
         JC_EQUAL:     cond_true = a_eq_m;
         JC_LESS:      cond_true = a_lt_m;
         JC_NOT_EQUAL: cond_true = ~a_eq_m;
         default:      cond_true = 1'b0;
      endcase
   end

   // L register
   always_ff @(posedge clk) begin
      if (state_alu) begin
         l_data <= result;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         jump_taken <= 1'b0;
      end else if (state_alu) begin
         jump_taken <= (kind == K_JUMP) & cond_true;   // Only jumps redirect
      end
   end

endmodule

/* hdl/operand_read.sv */
// A and M scratchpads, operand latches and L write-back with its external view
`timescale 1ns/1ps

module operand_read (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic                                  state_read,   // Latch operands
   input  logic                                  state_write,  // Write back L
   input  ucode_pkg::uinst_t                     ir,
   input  ucode_pkg::data_t                      l_data,
   output ucode_pkg::data_t                      a_op,
   output ucode_pkg::data_t                      m_op,
   output logic                                  wb_strobe,
   output logic                                  wb_a,
   output logic                                  wb_m,
   output logic [ucode_pkg::A_ADDR_W-1:0]        wb_addr,
   output ucode_pkg::data_t                      wb_data
);

   import ucode_pkg::*;

   data_t                 a_mem [2**A_ADDR_W];  // A scratchpad, 16 words
   data_t                 m_mem [2**M_ADDR_W];  // M scratchpad, 8 words
   uinst_kind_e           kind;
   logic [A_ADDR_W-1:0]   a_src;
   logic [M_ADDR_W-1:0]   m_src;
   logic [A_ADDR_W-1:0]   dst_addr;
   logic                  writes_l;             // ALU or BYTE kind

   assign kind     = uinst_kind_e'(ir[KIND_HI:KIND_LO]);
   assign a_src    = ir[A_SRC_HI:A_SRC_LO];
   assign m_src    = ir[M_SRC_HI:M_SRC_LO];
   assign dst_addr = ir[DEST_ADDR_HI:DEST_ADDR_LO];
   assign writes_l = (kind == K_ALU) || (kind == K_BYTE);

   ////////////////////
   // Write-back port
   assign wb_a      = ir[DEST_A_BIT];
   assign wb_m      = ir[DEST_M_BIT];
   assign wb_addr   = dst_addr;
   assign wb_data   = l_data;
   assign wb_strobe = state_write & writes_l & (wb_a | wb_m);

   always_ff @(posedge clk) begin
      if (reset) begin
         a_mem <= '{default: '0};               // Both pads read zero
         m_mem <= '{default: '0};
      end else if (wb_strobe) begin
         if (wb_a) a_mem[dst_addr] <= l_data;
         if (wb_m) m_mem[dst_addr[M_ADDR_W-1:0]] <= l_data;   // Low 3 bits
      end
   end

   // Operand latches
   always_ff @(posedge clk) begin
      if (state_read) begin
         a_op <= a_mem[a_src];
         m_op <= m_mem[m_src];
      end
   end

endmodule

/* hdl/useq.sv */
// Microcode sequencer with one-hot state, program counter, next address and halt flag
`timescale 1ns/1ps

module useq #(
   parameter int PC_W = 8
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                run,             // Level that holds machine in decode
   input  ucode_pkg::uinst_t   ir,
   input  logic                jump_taken,      // Registered at ALU
   output logic                state_read,
   output logic                state_alu,
   output logic                state_write,
   output logic                state_fetch,
   output logic [PC_W-1:0]     pc,              // Address of instruction in IR
   output logic [PC_W-1:0]     fetch_addr,
   output logic                halted
);

   import ucode_pkg::*;

   ucode_state_e                   state;
   ucode_state_e                   next_state;
   logic                           machrun;    // Run and not halted
   logic                           halt_inst;
   logic [TARGET_HI-TARGET_LO:0]   target;

   assign state_read   = state[1];
   assign state_alu    = state[2];
   assign state_write  = state[3];
   assign state_fetch  = state[4];

   assign machrun   = run & ~halted;
   assign halt_inst = ir[HALT_BIT];
   assign target    = ir[TARGET_HI:TARGET_LO];

   ////////////////////
   // State sequence
   always_comb begin
      next_state = ST_DECODE;
      unique case (state)
         ST_RESET:  next_state = ST_DECODE;
         ST_DECODE: next_state = machrun ? ST_READ : ST_DECODE;
         ST_READ:   next_state = ST_ALU;
         ST_ALU:    next_state = ST_WRITE;
         ST_WRITE:  next_state = halt_inst ? ST_DECODE : ST_FETCH;   // Halt skips fetch
         ST_FETCH:  next_state = ST_DECODE;
         default:   next_state = ST_DECODE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= ST_RESET;
      end else begin
         state <= next_state;
      end
   end

   ////////////////////
   // Next address and PC
   assign fetch_addr = jump_taken ? target[PC_W-1:0] : pc + 1'b1;    // Wraps

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '1;                              // First fetch is address 0
      end else if (state_fetch) begin
         pc <= fetch_addr;
      end
   end

   // Sticky halt flag cleared only by reset
   always_ff @(posedge clk) begin
      if (reset) begin
         halted <= 1'b0;
      end else if (state_write && halt_inst) begin
         halted <= 1'b1;
      end
   end

endmodule

/* hdl/uinst_store.sv */
// Writable microinstruction memory with load port, and the instruction register
`timescale 1ns/1ps

module uinst_store #(
   parameter int PC_W = 8                       // Store holds 2^PC_W words
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                state_fetch,     // IR load strobe
   input  logic [PC_W-1:0]     fetch_addr,
   input  logic                prog_we,         // Load port, machine stopped
   input  logic [PC_W-1:0]     prog_addr,
   input  ucode_pkg::uinst_t   prog_data,
   output ucode_pkg::uinst_t   ir
);

   import ucode_pkg::*;

   uinst_t store [2**PC_W];                     // Microcode RAM

   ////////////////////
   // Load port
   always_ff @(posedge clk) begin
      if (prog_we) begin
         store[prog_addr] <= prog_data;         // One word per strobe
      end
   end

   ////////////////////
   // Instruction register
   // Resets to the no-op, so the first pass through the sequence does
   // nothing and then fetches address 0
   always_ff @(posedge clk) begin
      if (reset) begin
         ir <= '0;                              // PASS_A, no destination
      end else if (state_fetch) begin
         ir <= store[fetch_addr];               // Next instruction
      end
   end

endmodule

/* hdl/ucode_pkg.sv */
// Data and microinstruction types, field positions, state, kind, ALU and jump encodings
package ucode_pkg;

   ////////////////////
   // Widths
   localparam int DATA_W   = 32;                // Data path
   localparam int IR_W     = 32;                // Microinstruction
   localparam int A_ADDR_W = 4;                 // 16 A-memory words
   localparam int M_ADDR_W = 3;                 // 8 M-memory words

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [IR_W-1:0]   uinst_t;          // All zeros is a no-op

   ////////////////////
   // Microinstruction fields
   localparam int HALT_BIT     = 31;
   localparam int KIND_HI      = 30;
   localparam int KIND_LO      = 29;
   localparam int FUNC_HI      = 28;            // ALU function or jump condition
   localparam int FUNC_LO      = 25;
   localparam int A_SRC_HI     = 24;
   localparam int A_SRC_LO     = 21;
   localparam int M_SRC_HI     = 20;
   localparam int M_SRC_LO     = 18;
   localparam int DEST_A_BIT   = 17;
   localparam int DEST_M_BIT   = 16;
   localparam int DEST_ADDR_HI = 15;            // M takes the low 3 bits
   localparam int DEST_ADDR_LO = 12;
   localparam int TARGET_HI    = 11;            // Jump target, low PC_W bits used
   localparam int TARGET_LO    = 0;
   localparam int ROT_HI       = 9;             // Left rotate count
   localparam int ROT_LO       = 5;
   localparam int MASK_W_HI    = 4;             // Mask width minus one
   localparam int MASK_W_LO    = 0;

   ////////////////////
   // Encodings
   typedef enum logic [4:0] {
      ST_RESET  = 5'b00000,                     // One cycle after reset only
      ST_DECODE = 5'b00001,
      ST_READ   = 5'b00010,
      ST_ALU    = 5'b00100,
      ST_WRITE  = 5'b01000,
      ST_FETCH  = 5'b10000
   } ucode_state_e;

   typedef enum logic [1:0] {
      K_ALU  = 2'd0,
      K_BYTE = 2'd1,
      K_JUMP = 2'd2
   } uinst_kind_e;

   typedef enum logic [3:0] {
      FN_PASS_A = 4'd0,
      FN_PASS_M = 4'd1,
      FN_ADD    = 4'd2,                         // A+M
      FN_SUB    = 4'd3,                         // A-M
      FN_AND    = 4'd4,
      FN_OR     = 4'd5,
      FN_XOR    = 4'd6,
      FN_INC_A  = 4'd7                          // Codes above give zero
   } alu_func_e;

   typedef enum logic [1:0] {
      JC_ALWAYS    = 2'd0,
      JC_EQUAL     = 2'd1,                      // A == M
      JC_LESS      = 2'd2,                      // A < M, signed
      JC_NOT_EQUAL = 2'd3
   } jump_cond_e;

endpackage
